//--- compile.f
+incdir+hw
hw/branch_stats_pkg.sv
hw/branch_tracker.sv
hw/credit_counter.sv
hw/stats_dump_fsm.sv
hw/branch_stats_top.sv
tb/tb_clock_gen.sv
tb/branch_stats_chk.sv
tb/branch_stats_tb.sv

//--- hw/branch_stats_config.svh
`ifndef BRANCH_STATS_CONFIG_SVH
`define BRANCH_STATS_CONFIG_SVH

// ************************************************************************
// branch statistics configuration.
// ************************************************************************

// width of every statistic counter and of the value field of a record.
`define BS_COUNT_W 32

// record slots the consumer grants at reset.
// this also sets the width of the credit counter.
`define BS_CREDITS 4

// the consumer must be able to hold at least one record.
// a value of zero would stall every dump forever.

`endif

//--- hw/branch_stats_pkg.sv
package branch_stats_pkg;

    `include "branch_stats_config.svh"

    // ************************************************************************
    // value and credit types.
    // ************************************************************************

    typedef logic [`BS_COUNT_W-1:0] count_t;                // one statistic value.
    typedef logic [$clog2(`BS_CREDITS+1)-1:0] credit_cnt_t; // holds 0 to BS_CREDITS.

    // statistic identifiers, listed in the order a dump walks them.
    typedef enum logic [3:0] {
        STAT_UNCOND,        // unconditional jumps.
        STAT_PRED,          // conditional branches resolved.
        STAT_MISPRED,
        STAT_CORRECT,
        STAT_PRED_T,
        STAT_PRED_NT,
        STAT_T_WRONG,       // predicted taken, was not taken.
        STAT_NT_WRONG,      // predicted not taken, was taken.
        STAT_FWD,
        STAT_FWD_PRED_T,
        STAT_FWD_T_OK,
        STAT_FWD_NT_OK,
        STAT_BWD,
        STAT_BWD_PRED_T,
        STAT_BWD_T_OK,
        STAT_BWD_NT_OK      // last record of a dump.
    } stat_id_t;

    // ************************************************************************
    // event, record and dump state.
    // ************************************************************************

    typedef struct packed {
        logic update;           // a conditional branch resolved this cycle.
        logic backward;         // target lies below the branch.
        logic predicted_taken;
        logic taken;            // actual outcome.
        logic is_jalr;          // unconditional jump.
    } branch_event_t;

    typedef struct packed {
        stat_id_t id;
        count_t   value;
    } stat_record_t;

    typedef enum logic [1:0] {DUMP_IDLE, DUMP_SEND, DUMP_DONE} dump_state_t;

endpackage

//--- hw/branch_stats_top.sv
module branch_stats_top
    import branch_stats_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,
    input  branch_event_t evt,
    input  logic          dump_req,
    input  logic          credit_return,
    output logic          rec_valid,
    output stat_record_t  rec,
    output logic          dump_done
);

    stat_id_t rd_id;        // statistic selected by the dump machine.
    count_t   rd_value;
    logic     credit_avail;
    logic     send;         // one record leaves this cycle.

    // ************************************************************************
    // statistic counters.
    // ************************************************************************

    branch_tracker u_tracker (
        .CLK      (CLK),
        .nRST     (nRST),
        .evt      (evt),
        .rd_id    (rd_id),
        .rd_value (rd_value)
    );

    // ************************************************************************
    // output flow control and dump sequencing.
    // ************************************************************************

    credit_counter u_credits (
        .CLK           (CLK),
        .nRST          (nRST),
        .send          (send),
        .credit_return (credit_return),
        .credit_avail  (credit_avail)
    );

    stats_dump_fsm u_dump (
        .CLK          (CLK),
        .nRST         (nRST),
        .dump_req     (dump_req),
        .credit_avail (credit_avail),
        .rd_value     (rd_value),
        .rd_id        (rd_id),
        .send         (send),
        .rec_valid    (rec_valid),
        .rec          (rec),
        .dump_done    (dump_done)
    );

endmodule

//--- hw/branch_tracker.sv
module branch_tracker
    import branch_stats_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,
    input  branch_event_t evt,
    input  stat_id_t      rd_id,
    output count_t        rd_value
);

    localparam int NUM_STATS = 16;

    count_t               counts [NUM_STATS];   // one counter per statistic id.
    logic [NUM_STATS-1:0] inc;                  // counters that step this cycle.
    logic                 pred_t;
    logic                 correct;

    assign pred_t  = evt.predicted_taken;
    assign correct = (evt.predicted_taken == evt.taken);

    // ************************************************************************
    // increment decode.
    // ************************************************************************

    // a jump overrides everything else on the event, so only the
    // unconditional counter moves even if update happens to be set.
    always_comb begin
        inc = '0;
        if (evt.is_jalr) begin
            inc[STAT_UNCOND] = 1'b1;
        end else if (evt.update) begin
            inc[STAT_PRED]     = 1'b1;
            inc[STAT_CORRECT]  = correct;
            inc[STAT_MISPRED]  = !correct;
            inc[STAT_PRED_T]   = pred_t;
            inc[STAT_PRED_NT]  = !pred_t;
            inc[STAT_T_WRONG]  = pred_t && !correct;
            inc[STAT_NT_WRONG] = !pred_t && !correct;

            // the direction picks one of the two per-direction sets.
            if (evt.backward) begin
                inc[STAT_BWD]        = 1'b1;
                inc[STAT_BWD_PRED_T] = pred_t;
                inc[STAT_BWD_T_OK]   = pred_t && correct;
                inc[STAT_BWD_NT_OK]  = !pred_t && correct;
            end else begin
                inc[STAT_FWD]        = 1'b1;
                inc[STAT_FWD_PRED_T] = pred_t;
                inc[STAT_FWD_T_OK]   = pred_t && correct;
                inc[STAT_FWD_NT_OK]  = !pred_t && correct;
            end
        end
    end

    // ************************************************************************
    // counters.
    // ************************************************************************

    // counters only ever clear at reset and wrap silently at full scale.
    for (genvar g = 0; g < NUM_STATS; g++) begin : g_cnt
        always_ff @(posedge CLK, negedge nRST) begin
            if (!nRST) begin
                counts[g] <= '0;
            end else if (inc[g]) begin
                counts[g] <= counts[g] + 1'b1;
            end
        end
    end

    // read port for the dump machine.
    // the value is the current counter output, so an event taken on the
    // same edge as a read is already included in the next cycle.
    assign rd_value = counts[rd_id];

endmodule

//--- hw/credit_counter.sv
`include "branch_stats_config.svh"

module credit_counter
    import branch_stats_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic send,
    input  logic credit_return,
    output logic credit_avail
);

    credit_cnt_t credits;   // free record slots at the consumer.

    // ************************************************************************
    // slot accounting.
    // ************************************************************************

    // the consumer starts with all of its slots free.
    // a send takes one slot and a returned credit gives one back, so both
    // in the same cycle cancel out.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credits <= credit_cnt_t'(`BS_CREDITS);
        end else begin
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign credit_avail = (credits != '0);  // at least one slot is free.

endmodule

//--- hw/stats_dump_fsm.sv
module stats_dump_fsm
    import branch_stats_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,
    input  logic         dump_req,
    input  logic         credit_avail,
    input  count_t       rd_value,
    output stat_id_t     rd_id,
    output logic         send,
    output logic         rec_valid,
    output stat_record_t rec,
    output logic         dump_done
);

    dump_state_t state;
    stat_id_t    cur_id;    // next statistic to put out.

    // ************************************************************************
    // walk control.
    // ************************************************************************

    // a record leaves whenever the consumer has a free slot. without a
    // credit the walk simply stalls on the current id.
    assign send  = (state == DUMP_SEND) && credit_avail;
    assign rd_id = cur_id;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= DUMP_IDLE;
            cur_id <= STAT_UNCOND;
        end else begin
            case (state)
                DUMP_IDLE: begin
                    if (dump_req) begin
                        state  <= DUMP_SEND;
                        cur_id <= STAT_UNCOND;
                    end
                end
                DUMP_SEND: begin
                    if (send) begin
                        if (cur_id == STAT_BWD_NT_OK) begin
                            state <= DUMP_DONE;
                        end else begin
                            cur_id <= stat_id_t'(cur_id + 4'd1);
                        end
                    end
                end
                DUMP_DONE: begin
                    // the last record is still on the output in the first
                    // cycle here. leave once it has gone.
                    if (!rec_valid) begin
                        state <= DUMP_IDLE;
                    end
                end
                default: state <= DUMP_IDLE;
            endcase
        end
    end

    // ************************************************************************
    // record output.
    // ************************************************************************

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= send;
        end
    end

    // payload only changes on a send and is qualified by rec_valid.
    always_ff @(posedge CLK) begin
        if (send) begin
            rec.id    <= cur_id;
            rec.value <= rd_value;
        end
    end

    // done shows in the cycle right after the last record, while the
    // machine still sits in DUMP_DONE.
    assign dump_done = (state == DUMP_DONE) && !rec_valid;

endmodule

//--- run.sh
#!/bin/sh
# Builds the branch statistics testbench with Verilator and runs it.
# The exit status is zero only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps \
        -f compile.f --top-module branch_stats_tb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x obj_dir/Vbranch_stats_tb ]; then
    echo "simulation binary is missing"
    exit 1
fi

out=$(./obj_dir/Vbranch_stats_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- tb/branch_stats_chk.sv
`include "branch_stats_config.svh"

module branch_stats_chk
    import branch_stats_pkg::*;
(
    input logic        CLK,
    input logic        nRST,
    input logic        rec_valid,
    input logic        dump_done,
    input logic        credit_avail,
    input credit_cnt_t credits,
    input dump_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    // a record on the output was sent in a cycle with a free consumer slot.
    a_credit_rule: assert property (@(posedge CLK) disable iff (!nRST)
        rec_valid |-> $past(credit_avail))
        else $error("record sent without a free consumer slot");

    a_done_alone: assert property (@(posedge CLK) disable iff (!nRST)
        !(dump_done && rec_valid))
        else $error("dump_done high together with a record");

    a_credit_max: assert property (@(posedge CLK) disable iff (!nRST)
        credits <= credit_cnt_t'(`BS_CREDITS))   // never more slots than granted.
        else $error("credit count above the number of consumer slots");

    // the done pulse ends the dump and the machine is idle right after it.
    a_done_idle: assert property (@(posedge CLK) disable iff (!nRST)
        dump_done |=> (state == DUMP_IDLE))
        else $error("dump machine did not return to idle after dump_done");

endmodule

bind branch_stats_top branch_stats_chk u_chk (
    .CLK          (CLK),
    .nRST         (nRST),
    .rec_valid    (rec_valid),
    .dump_done    (dump_done),
    .credit_avail (credit_avail),
    .credits      (u_credits.credits),
    .state        (u_dump.state)
);

//--- tb/branch_stats_tb.sv
`include "branch_stats_config.svh"

module branch_stats_tb
    import branch_stats_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_STATS  = 16;
    localparam int WAIT_LIMIT = 400;    // cycles any single wait may take.

    logic          CLK;
    logic          nRST;
    branch_event_t evt;
    logic          dump_req;
    logic          credit_return;
    logic          rec_valid;
    stat_record_t  rec;
    logic          dump_done;

    count_t       model [NUM_STATS];    // expected value of every statistic.
    stat_record_t rec_q [$];            // records taken by the consumer.
    logic [15:0]  lfsr;
    logic [7:0]   combos_seen;          // prediction, outcome and direction seen.
    logic         hold_credits;         // consumer keeps its slots.
    logic         fast_return;          // consumer frees a slot without a pause.
    int           held;
    int           done_cnt;
    int           exp_idx;              // next id the compare process expects.
    int           checks;
    int           errors;
    string        test_name;

    tb_clock_gen u_clk (.CLK(CLK), .nRST(nRST));

    branch_stats_top u_dut (
        .CLK           (CLK),
        .nRST          (nRST),
        .evt           (evt),
        .dump_req      (dump_req),
        .credit_return (credit_return),
        .rec_valid     (rec_valid),
        .rec           (rec),
        .dump_done     (dump_done)
    );

    // ************************************************************************
    // helpers.
    // ************************************************************************

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return b;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic void bump(input stat_id_t id);
        model[id] = model[id] + 1'b1;
    endfunction

    // reference model. a jump counts only as a jump; a conditional branch
    // counts by outcome and then in the set of its direction.
    function automatic void model_event(input branch_event_t e);
        logic ok;
        ok = (e.predicted_taken == e.taken);
        if (e.is_jalr) begin
            bump(STAT_UNCOND);
        end else if (e.update) begin
            bump(STAT_PRED);
            if (ok) bump(STAT_CORRECT);
            else    bump(STAT_MISPRED);
            if (e.predicted_taken) begin
                bump(STAT_PRED_T);
                if (!ok) bump(STAT_T_WRONG);
            end else begin
                bump(STAT_PRED_NT);
                if (!ok) bump(STAT_NT_WRONG);
            end
            if (e.backward) begin
                bump(STAT_BWD);
                if (e.predicted_taken) bump(STAT_BWD_PRED_T);
                if (e.predicted_taken && ok) bump(STAT_BWD_T_OK);
                if (!e.predicted_taken && ok) bump(STAT_BWD_NT_OK);
            end else begin
                bump(STAT_FWD);
                if (e.predicted_taken) bump(STAT_FWD_PRED_T);
                if (e.predicted_taken && ok) bump(STAT_FWD_T_OK);
                if (!e.predicted_taken && ok) bump(STAT_FWD_NT_OK);
            end
        end
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    // kind 0 gives conditional branches, 1 gives jumps, 2 any mix of fields.
    task automatic random_events(input int n, input int kind);
        branch_event_t e;
        int i;
        for (i = 0; i < n; i++) begin
            e.update          = (kind == 0) ? 1'b1 : random_bit();
            e.backward        = random_bit();
            e.predicted_taken = random_bit();
            e.taken           = random_bit();
            e.is_jalr         = (kind == 1) ? 1'b1 : ((kind == 2) ? random_bit() : 1'b0);
            if (kind == 0) combos_seen[{e.predicted_taken, e.taken, e.backward}] = 1'b1;
            next_cycle();
            evt = e;
            model_event(e);
        end
        next_cycle();
        evt = '0;
    endtask

    task automatic run_dump(input string name, input int hold_cycles, input logic extra_req);
        int k;
        int first;
        int last;
        int done_at;
        int done_before;
        k = 0;
        while (held != 0 && k < WAIT_LIMIT) begin  // all slots back first.
            next_cycle();
            k++;
        end
        if (held != 0) begin
            errors++;
            $display("%s: consumer never freed its slots before the dump", name);
        end
        test_name    = name;
        exp_idx      = 0;
        done_before  = done_cnt;
        hold_credits = (hold_cycles > 0);
        next_cycle();
        dump_req = 1'b1;
        next_cycle();
        dump_req = 1'b0;
        if (hold_cycles > 0) begin
            repeat (hold_cycles) next_cycle();
            check_equal({name, " records before credit"}, 64'(`BS_CREDITS), 64'(exp_idx));
            check_equal({name, " early done"}, 64'(done_before), 64'(done_cnt));
            hold_credits = 1'b0;
        end
        k       = 0;
        first   = -1;
        last    = -1;
        done_at = -1;
        while (done_at < 0 && k < WAIT_LIMIT) begin
            next_cycle();
            dump_req = extra_req && (k == 4);       // a request in mid walk.
            if (rec_valid) begin
                if (first < 0) first = k;
                last = k;
            end
            if (dump_done) done_at = k;
            k++;
        end
        dump_req = 1'b0;
        if (done_at < 0) begin
            errors++;
            $display("%s: dump_done never arrived", name);
        end else begin
            check_equal({name, " done after last record"}, 64'(last + 1), 64'(done_at));
            if (fast_return && hold_cycles == 0) begin
                check_equal({name, " back to back records"}, 64'd15, 64'(last - first));
            end
        end
        repeat (4) next_cycle();
        check_equal({name, " record count"}, 64'(NUM_STATS), 64'(exp_idx));
        check_equal({name, " done pulses"}, 64'(done_before + 1), 64'(done_cnt));
    endtask

    // ************************************************************************
    // consumer and compare.
    // ************************************************************************

    // records are taken at mid cycle. a slot is freed one at a time, after a
    // short random pause unless the fast mode is on.
    initial begin : consumer
        logic [1:0] pause;
        logic       give;
        pause         = '0;
        credit_return = 1'b0;
        forever begin
            @(negedge CLK);
            give = 1'b0;
            if (rec_valid) begin
                rec_q.push_back(rec);
                held++;
                if (held > `BS_CREDITS) begin
                    errors++;
                    $display("consumer holds more records than it granted slots");
                end
            end
            if (dump_done) done_cnt++;
            if (held > 0 && !hold_credits) begin
                if (pause == 0 || fast_return) begin
                    give  = 1'b1;
                    held--;
                    pause = fast_return ? 2'd0 : {random_bit(), random_bit()};
                end else begin
                    pause--;
                end
            end
            @(posedge CLK);
            #2;
            credit_return = give;
        end
    end

    always @(posedge CLK) begin : compare
        stat_record_t r;
        while (rec_q.size() > 0) begin
            r = rec_q.pop_front();
            if (exp_idx >= NUM_STATS) begin
                errors++;
                $display("%s: record arrived after the sixteenth", test_name);
            end else begin
                check_equal($sformatf("%s id %0d", test_name, exp_idx),
                            64'(exp_idx), 64'(r.id));
                check_equal($sformatf("%s value %0d", test_name, exp_idx),
                            64'(model[exp_idx]), 64'(r.value));
            end
            exp_idx++;
        end
    end

    // ************************************************************************
    // test sequence.
    // ************************************************************************

    initial begin : main
        int i;
        errors       = 0;
        checks       = 0;
        held         = 0;
        done_cnt     = 0;
        exp_idx      = 0;
        test_name    = "reset";
        lfsr         = 16'd46836;
        combos_seen  = '0;
        hold_credits = 1'b0;
        fast_return  = 1'b1;
        evt          = '0;
        dump_req     = 1'b0;
        for (i = 0; i < NUM_STATS; i++) model[i] = '0;
        i = 0;
        while (nRST !== 1'b1 && i < WAIT_LIMIT) begin
            next_cycle();
            i++;
        end
        if (nRST !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end
        repeat (3) begin
            next_cycle();
            check_equal("reset rec_valid", 64'd0, 64'(rec_valid));
            check_equal("reset dump_done", 64'd0, 64'(dump_done));
        end
        run_dump("reset", 0, 1'b0);

        fast_return = 1'b0;
        random_events(300, 0);
        check_equal("branch combinations", 64'hff, 64'(combos_seen));
        run_dump("conditional", 0, 1'b0);

        fast_return = 1'b1;
        random_events(40, 1);
        run_dump("jump", 0, 1'b0);

        fast_return = 1'b0;
        run_dump("back-pressure", 12, 1'b0);

        random_events(100, 2);
        run_dump("accumulate", 0, 1'b1);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;   // 40 ns clock.
    localparam int RESET_CYCLES = 3;

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // reset lets go just after the third rising edge, like any other input.
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 nRST = 1'b1;
    end

endmodule
